// File: hw/mem_system_settings.svh
`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

// Address split is tag | index | byte offset
`define ADDR_W 16
`define DATA_W 16
`define TAG_W 5
`define INDEX_W 8
`define OFFSET_W 3

`define CACHE_LINES 256
`define LINE_WORDS 4
`define MEM_WORDS 32768
`define MEM_RD_LAT 2

`endif

// File: hw/mem_system_pkg.sv
package mem_system_pkg;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_CMP_RD_0,
		ST_CMP_WR_0,
		ST_HIT,
		ST_WB_0,
		ST_WB_1,
		ST_WB_2,
		ST_WB_3,
		ST_FILL_0,
		ST_FILL_1,
		ST_FILL_2,
		ST_FILL_3,
		ST_FILL_4,
		ST_FILL_5,
		ST_CMP_RD_1,
		ST_CMP_WR_1
	} ctrl_state_t;

	// Line write bypasses the tag compare
	typedef enum logic [1:0] {
		CACHE_NONE,
		CACHE_CMP_RD,
		CACHE_CMP_WR,
		CACHE_LINE_WR
	} cache_op_t;

endpackage

// File: hw/cache_array.sv
`timescale 1ns/1ps
`include "mem_system_settings.svh"

module cache_array (
	input  logic                      clk,
	input  logic                      rst,
	input  mem_system_pkg::cache_op_t cache_op,
	input  logic [`INDEX_W-1:0]       index,
	input  logic [`OFFSET_W-1:0]      offset,
	input  logic [`TAG_W-1:0]         tag_in,
	input  logic [`DATA_W-1:0]        cache_data_in,
	input  logic                      valid_in,
	output logic                      hit,
	output logic                      dirty,
	output logic                      valid,
	output logic [`TAG_W-1:0]         tag_out,
	output logic [`DATA_W-1:0]        cache_data_out
);
	import mem_system_pkg::*;

	localparam int WORD_W = $clog2(`LINE_WORDS);

	logic [`TAG_W-1:0]  tag_mem  [`CACHE_LINES];
	logic [`DATA_W-1:0] data_mem [`CACHE_LINES][`LINE_WORDS];
	logic [`CACHE_LINES-1:0] valid_bits;
	logic [`CACHE_LINES-1:0] dirty_bits;

	logic [WORD_W-1:0] word;
	logic              cmp_wr_en;
	logic              line_wr_en;

	// Byte offset bit 0 is ignored, requests are word aligned
	assign word = offset[`OFFSET_W-1:1];

	assign tag_out        = tag_mem[index];
	assign valid          = valid_bits[index];
	assign dirty          = dirty_bits[index];
	assign hit            = (tag_mem[index] == tag_in);
	assign cache_data_out = data_mem[index][word];

	assign cmp_wr_en  = (cache_op == CACHE_CMP_WR) && hit && valid;
	assign line_wr_en = (cache_op == CACHE_LINE_WR);

	always_ff @(posedge clk)
	begin
		if (cmp_wr_en || line_wr_en)
			data_mem[index][word] <= cache_data_in;
		if (line_wr_en)
			tag_mem[index] <= tag_in;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (line_wr_en)
		begin
			valid_bits[index] <= valid_in;
			dirty_bits[index] <= 1'b0;
		end
		else if (cmp_wr_en)
		begin
			dirty_bits[index] <= 1'b1;
		end
	end

endmodule

// File: hw/four_bank_mem.sv
`timescale 1ns/1ps
`include "mem_system_settings.svh"

module four_bank_mem (
	input  logic               clk,
	input  logic [`ADDR_W-1:0] mem_addr,
	input  logic [`DATA_W-1:0] mem_data_in,
	input  logic               mem_wr,
	input  logic               mem_rd,
	output logic [`DATA_W-1:0] mem_data_out
);

	localparam int BANKS  = 4;
	localparam int BANK_W = $clog2(BANKS);
	localparam int ROWS   = `MEM_WORDS / BANKS;
	localparam int ROW_W  = $clog2(ROWS);

	logic [`DATA_W-1:0] bank_mem [BANKS][ROWS];
	logic [`DATA_W-1:0] rd_pipe  [`MEM_RD_LAT];

	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0]  row;

	// Consecutive words sit in consecutive banks
	assign bank = mem_addr[BANK_W:1];
	assign row  = mem_addr[`ADDR_W-1 -: ROW_W];

	initial
	begin
		for (int b = 0; b < BANKS; b++)
		begin
			for (int r = 0; r < ROWS; r++)
				bank_mem[b][r] = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_wr)
			bank_mem[bank][row] <= mem_data_in;
	end

	// Read data walks the pipeline, one stage per cycle
	always_ff @(posedge clk)
	begin
		rd_pipe[0] <= mem_rd ? bank_mem[bank][row] : '0;
		for (int i = 1; i < `MEM_RD_LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign mem_data_out = rd_pipe[`MEM_RD_LAT-1];

endmodule

// File: hw/cache_controller.sv
`timescale 1ns/1ps
`include "mem_system_settings.svh"

module cache_controller (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rd,
	input  logic                      wr,
	input  logic [`ADDR_W-1:0]        addr,
	input  logic [`DATA_W-1:0]        data_in,
	input  logic                      hit,
	input  logic                      dirty,
	input  logic                      valid,
	input  logic [`TAG_W-1:0]         tag_out,
	input  logic [`DATA_W-1:0]        cache_data_out,
	input  logic [`DATA_W-1:0]        mem_data_out,
	output mem_system_pkg::cache_op_t cache_op,
	output logic [`INDEX_W-1:0]       index,
	output logic [`OFFSET_W-1:0]      offset,
	output logic [`TAG_W-1:0]         tag_in,
	output logic [`DATA_W-1:0]        cache_data_in,
	output logic                      valid_in,
	output logic [`ADDR_W-1:0]        mem_addr,
	output logic [`DATA_W-1:0]        mem_data_in,
	output logic                      mem_wr,
	output logic                      mem_rd,
	output logic                      done,
	output logic                      cache_hit,
	output logic                      stall
);
	import mem_system_pkg::*;

	localparam int WORD_W = $clog2(`LINE_WORDS);

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic              wb_en;
	logic              rd_en;
	logic              fill_en;
	logic [WORD_W-1:0] wb_word;
	logic [WORD_W-1:0] rd_word;
	logic [WORD_W-1:0] fill_word;

	logic [`TAG_W-1:0]   req_tag;
	logic [`INDEX_W-1:0] req_index;

	assign req_tag   = addr[`ADDR_W-1 -: `TAG_W];
	assign req_index = addr[`OFFSET_W +: `INDEX_W];

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		cache_op   = CACHE_NONE;
		done       = 1'b0;
		cache_hit  = 1'b0;
		stall      = 1'b1;
		wb_en      = 1'b0;
		rd_en      = 1'b0;
		fill_en    = 1'b0;
		wb_word    = '0;
		rd_word    = '0;
		fill_word  = '0;

		case (state)
			ST_IDLE:
			begin
				stall = 1'b0;
				if (rd)
					next_state = ST_CMP_RD_0;
				else if (wr)
					next_state = ST_CMP_WR_0;
			end
			ST_CMP_RD_0, ST_CMP_WR_0:
			begin
				cache_op = (state == ST_CMP_WR_0) ? CACHE_CMP_WR : CACHE_CMP_RD;
				if (hit && valid)
					next_state = ST_HIT;
				else if (valid && dirty)
					next_state = ST_WB_0;
				else
					next_state = ST_FILL_0;
			end
			ST_HIT:
			begin
				done       = 1'b1;
				cache_hit  = 1'b1;
				next_state = ST_IDLE;
			end
			// Victim line goes out one word per cycle
			ST_WB_0: begin wb_en = 1'b1; wb_word = 2'd0; next_state = ST_WB_1; end
			ST_WB_1: begin wb_en = 1'b1; wb_word = 2'd1; next_state = ST_WB_2; end
			ST_WB_2: begin wb_en = 1'b1; wb_word = 2'd2; next_state = ST_WB_3; end
			ST_WB_3: begin wb_en = 1'b1; wb_word = 2'd3; next_state = ST_FILL_0; end
			// Reads lead the line writes by the memory latency
			ST_FILL_0: begin rd_en = 1'b1; rd_word = 2'd0; next_state = ST_FILL_1; end
			ST_FILL_1: begin rd_en = 1'b1; rd_word = 2'd1; next_state = ST_FILL_2; end
			ST_FILL_2:
			begin
				rd_en      = 1'b1;
				rd_word    = 2'd2;
				fill_en    = 1'b1;
				fill_word  = 2'd0;
				next_state = ST_FILL_3;
			end
			ST_FILL_3:
			begin
				rd_en      = 1'b1;
				rd_word    = 2'd3;
				fill_en    = 1'b1;
				fill_word  = 2'd1;
				next_state = ST_FILL_4;
			end
			ST_FILL_4: begin fill_en = 1'b1; fill_word = 2'd2; next_state = ST_FILL_5; end
			ST_FILL_5:
			begin
				fill_en   = 1'b1;
				fill_word = 2'd3;
				if (rd)
					next_state = ST_CMP_RD_1;
				else if (wr)
					next_state = ST_CMP_WR_1;
				else
					next_state = ST_IDLE;
			end
			ST_CMP_RD_1, ST_CMP_WR_1:
			begin
				cache_op   = (state == ST_CMP_WR_1) ? CACHE_CMP_WR : CACHE_CMP_RD;
				done       = 1'b1;
				next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase

		if (fill_en)
			cache_op = CACHE_LINE_WR;
	end

	// Cache side addressing
	assign index    = req_index;
	assign tag_in   = req_tag;
	assign valid_in = fill_en;
	assign offset   = wb_en   ? {wb_word, 1'b0} :
	                  fill_en ? {fill_word, 1'b0} : addr[`OFFSET_W-1:0];
	assign cache_data_in = fill_en ? mem_data_out : data_in;

	// Memory side, victim address rebuilt from the stored tag
	assign mem_wr      = wb_en;
	assign mem_rd      = rd_en;
	assign mem_data_in = cache_data_out;
	assign mem_addr    = wb_en ? {tag_out, req_index, wb_word, 1'b0} :
	                     rd_en ? {req_tag, req_index, rd_word, 1'b0} : '0;

endmodule

// File: hw/mem_system.sv
`timescale 1ns/1ps
`include "mem_system_settings.svh"

module mem_system (
	input  logic               clk,
	input  logic               rst,
	input  logic               rd,
	input  logic               wr,
	input  logic [`ADDR_W-1:0] addr,
	input  logic [`DATA_W-1:0] data_in,
	output logic [`DATA_W-1:0] data_out,
	output logic               done,
	output logic               cache_hit,
	output logic               stall
);
	import mem_system_pkg::*;

	cache_op_t            cache_op;
	logic [`INDEX_W-1:0]  index;
	logic [`OFFSET_W-1:0] offset;
	logic [`TAG_W-1:0]    tag_in;
	logic [`TAG_W-1:0]    tag_out;
	logic [`DATA_W-1:0]   cache_data_in;
	logic                 valid_in;
	logic                 hit;
	logic                 dirty;
	logic                 valid;
	logic [`ADDR_W-1:0]   mem_addr;
	logic [`DATA_W-1:0]   mem_data_in;
	logic [`DATA_W-1:0]   mem_data_out;
	logic                 mem_wr;
	logic                 mem_rd;

	// data_out is the cache read port itself
	cache_controller u_ctrl (
		.clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
		.hit(hit), .dirty(dirty), .valid(valid), .tag_out(tag_out),
		.cache_data_out(data_out), .mem_data_out(mem_data_out),
		.cache_op(cache_op), .index(index), .offset(offset), .tag_in(tag_in),
		.cache_data_in(cache_data_in), .valid_in(valid_in),
		.mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_wr(mem_wr), .mem_rd(mem_rd),
		.done(done), .cache_hit(cache_hit), .stall(stall)
	);

	cache_array u_cache (
		.clk(clk), .rst(rst), .cache_op(cache_op), .index(index), .offset(offset),
		.tag_in(tag_in), .cache_data_in(cache_data_in), .valid_in(valid_in),
		.hit(hit), .dirty(dirty), .valid(valid), .tag_out(tag_out),
		.cache_data_out(data_out)
	);

	four_bank_mem u_mem (
		.clk(clk), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
		.mem_wr(mem_wr), .mem_rd(mem_rd), .mem_data_out(mem_data_out)
	);

endmodule

// File: sim/mem_system_properties.sv
`timescale 1ns/1ps

module mem_system_properties (
	input logic                        clk,
	input logic                        rst,
	input logic                        rd,
	input logic                        wr,
	input logic                        done,
	input logic                        cache_hit,
	input logic                        stall,
	input logic                        mem_rd,
	input logic                        mem_wr,
	input mem_system_pkg::ctrl_state_t ctrl_state
);
	import mem_system_pkg::*;

	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Memory port is either reading or writing
	mem_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
		else $error("mem_rd and mem_wr high in the same cycle");

	// A request taken in idle moves the controller on
	stall_idle: assert property (@(posedge clk) disable iff (rst)
		!stall && (rd || wr) |=> ctrl_state != ST_IDLE)
		else $error("controller stayed idle after taking a request");

	reset_quiet: assert property (@(posedge clk) rst |=> !done && !cache_hit)
		else $error("done or cache_hit high right after reset");

endmodule

bind mem_system mem_system_properties u_props (
	.clk(clk), .rst(rst), .rd(rd), .wr(wr), .done(done), .cache_hit(cache_hit),
	.stall(stall), .mem_rd(mem_rd), .mem_wr(mem_wr), .ctrl_state(u_ctrl.state)
);

// File: sim/mem_system_tb.sv
`timescale 1ns/1ps
`include "mem_system_settings.svh"

module mem_system_tb;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_REQS   = 63;
	localparam int REQ_LIMIT  = 20;

	logic               clk;
	logic               rst;
	logic               rd;
	logic               wr;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] data_in;
	logic [`DATA_W-1:0] data_out;
	logic               done;
	logic               cache_hit;
	logic               stall;

	// Model keeps the processor's view of memory plus tag state per line
	logic [`DATA_W-1:0]      model_mem [`MEM_WORDS];
	logic [`TAG_W-1:0]       model_tag [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] model_valid;
	logic [`CACHE_LINES-1:0] model_dirty;

	int     errors;
	int     requests;
	integer seed;

	mem_system dut (
		.clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
		.data_out(data_out), .done(done), .cache_hit(cache_hit), .stall(stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Dirty miss plus two idle cycles bounds each request
	initial
	begin
		#((NUM_REQS * 14 + 50) * CLK_PERIOD);
		$display("Watchdog expired at %0t, the DUT stopped finishing requests", $time);
		$display("Test FAILED");
		$finish;
	end

	task automatic access_and_check(input logic is_wr, input logic [`ADDR_W-1:0] a,
		input logic [`DATA_W-1:0] d);
		logic [`INDEX_W-1:0] idx;
		logic [`TAG_W-1:0]   tag;
		logic                exp_hit;
		logic [`DATA_W-1:0]  exp_data;
		int                  exp_lat;
		int                  cycles;
		idx      = a[`OFFSET_W +: `INDEX_W];
		tag      = a[`ADDR_W-1 -: `TAG_W];
		exp_hit  = model_valid[idx] && (model_tag[idx] == tag);
		exp_lat  = exp_hit ? 2 : ((model_valid[idx] && model_dirty[idx]) ? 12 : 8);
		exp_data = model_mem[a[`ADDR_W-1:1]];
		if (!exp_hit)
		begin
			model_tag[idx]   = tag;
			model_valid[idx] = 1'b1;
			model_dirty[idx] = 1'b0;
		end
		if (is_wr)
		begin
			model_dirty[idx]            = 1'b1;
			model_mem[a[`ADDR_W-1:1]] = d;
		end
		requests++;

		@(posedge clk);
		#1;
		rd      = !is_wr;
		wr      = is_wr;
		addr    = a;
		data_in = d;
		@(negedge clk);
		if (stall)
		begin
			errors++;
			$display("Request to %h at %0t issued while the controller was busy", a, $time);
		end
		cycles = 0;
		while (!done && cycles < REQ_LIMIT)
		begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		if (!done)
		begin
			errors++;
			$display("No done pulse within %0d cycles for address %h", REQ_LIMIT, a);
		end
		else
		begin
			if (cycles != exp_lat)
			begin
				errors++;
				$display("ERROR at %0t: done latency = %0d, expected %0d (addr %h)",
					$time, cycles, exp_lat, a);
			end
			if (cache_hit !== exp_hit)
			begin
				errors++;
				$display("ERROR at %0t: cache_hit = %b, expected %b (addr %h)",
					$time, cache_hit, exp_hit, a);
			end
			if (!is_wr && data_out !== exp_data)
			begin
				errors++;
				$display("ERROR at %0t: data_out = %h, expected %h (addr %h)",
					$time, data_out, exp_data, a);
			end
		end
		@(posedge clk);
		#1;
		rd = 1'b0;
		wr = 1'b0;
	endtask

	// Cold miss, then another word of the same line
	task automatic reset_miss_then_hit;
		access_and_check(1'b0, 16'h1234, '0);
		access_and_check(1'b0, 16'h1236, '0);
	endtask

	task automatic write_miss_readback;
		access_and_check(1'b1, 16'h2a40, 16'hbeef);
		access_and_check(1'b0, 16'h2a40, '0);
		access_and_check(1'b0, 16'h2a42, '0);
		access_and_check(1'b0, 16'h2a44, '0);
		access_and_check(1'b0, 16'h2a46, '0);
	endtask

	// Conflicting tag flips address bit 11
	task automatic dirty_eviction;
		access_and_check(1'b0, 16'h0530, '0);
		access_and_check(1'b1, 16'h0530, 16'h5a5a);
		access_and_check(1'b0, 16'h0d30, '0);
		access_and_check(1'b0, 16'h0530, '0);
	endtask

	task automatic clean_conflict_miss;
		access_and_check(1'b0, 16'h3318, '0);
		access_and_check(1'b0, 16'h7318, '0);
	endtask

	task automatic random_traffic;
		logic [31:0]        r;
		logic [31:0]        rd_data;
		logic [`ADDR_W-1:0] a;
		for (int i = 0; i < 50; i++)
		begin
			r       = $random(seed);
			rd_data = $random(seed);
			// Four tags over four neighbouring lines
			a = {3'b000, r[1:0], 6'h10, r[3:2], r[5:4], 1'b0};
			access_and_check(r[6], a, rd_data[15:0]);
		end
	endtask

	initial
	begin
		errors      = 0;
		requests    = 0;
		seed        = 32'hff8bb224;
		rst         = 1'b1;
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = '0;
		data_in     = '0;
		model_valid = '0;
		model_dirty = '0;
		for (int i = 0; i < `MEM_WORDS; i++)
			model_mem[i] = '0;
		for (int i = 0; i < `CACHE_LINES; i++)
			model_tag[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		reset_miss_then_hit;
		write_miss_readback;
		dirty_eviction;
		clean_conflict_miss;
		random_traffic;

		$display("Requests: %0d, errors: %0d", requests, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hw
hw/mem_system_pkg.sv
hw/cache_array.sv
hw/four_bank_mem.sv
hw/cache_controller.sv
hw/mem_system.sv
sim/mem_system_properties.sv
sim/mem_system_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module mem_system_tb \
	-o sim_mem_system || exit 1
out=$(./obj_dir/sim_mem_system 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK' && echo "Simulation passed" || {
	echo "Simulation did not pass"
	exit 1
}
